/* build.f */
+incdir+common
common/exu_pkg.sv
design/alu.sv
design/branch_unit.sv
lsu/lsu.sv
design/exu_control.sv
design/execute_stage.sv
sim/wb_mem_model.sv
sim/tb_execute_stage.sv

/* common/exu_config.svh */
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// datapath word width
`define EXU_WORD_BITS 32

// register file index width
`define EXU_GPR_ADDR_BITS 5

// wishbone byte select width, one bit per byte lane
`define EXU_SEL_BITS (`EXU_WORD_BITS / 8)

// sequential pc increment
// also the link value offset for jal and jalr
`define EXU_PC_STEP 4

`endif

/* common/exu_pkg.sv */
`default_nettype none

`include "exu_config.svh"

package exu_pkg;

  // data and address word
  typedef logic [`EXU_WORD_BITS-1:0] word_t;

  // register index, zero means no write
  typedef logic [`EXU_GPR_ADDR_BITS-1:0] gpr_addr_t;

  // alu operation
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,
    alu_sltu = 4'd4,
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } alu_op_e;

  // jump kind
  // branches test the alu result against zero
  typedef enum logic [2:0] {
    jmp_none       = 3'd0,
    jmp_jal        = 3'd1,
    jmp_jalr       = 3'd2,
    jmp_br_zero    = 3'd3,
    jmp_br_nonzero = 3'd4
  } jump_e;

  // memory operation
  typedef enum logic [3:0] {
    mem_none = 4'd0,
    mem_lb   = 4'd1,
    mem_lh   = 4'd2,
    mem_lw   = 4'd3,
    mem_lbu  = 4'd4,
    mem_lhu  = 4'd5,
    mem_sb   = 4'd6,
    mem_sh   = 4'd7,
    mem_sw   = 4'd8
  } mem_e;

  // write-back source
  typedef enum logic [1:0] {
    src_alu     = 2'd0,
    src_operand = 2'd1,
    src_mem     = 2'd2,
    src_link    = 2'd3
  } wb_src_e;

endpackage

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu import exu_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e op,
  output word_t   result
);

  // shift amount from low five bits of b
  logic [4:0] shamt;
  // signed and unsigned compare flags
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    result = '0;
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      // set-less-than gives 0 or 1
      alu_slt:  result[0] = lt_signed;
      alu_sltu: result[0] = lt_unsigned;
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      // arithmetic shift keeps the sign bit
      alu_sra:  result = word_t'($signed(a) >>> shamt);
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/branch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exu_config.svh"

module branch_unit import exu_pkg::*; (
  input  jump_e jump,
  input  word_t pc,
  input  word_t val_a,
  input  word_t val_c,
  input  word_t alu_result,
  output logic  mispredict,
  output word_t redirect_pc
);

  // candidate next pcs
  word_t seq_pc;
  word_t rel_pc;
  word_t ind_sum;
  // actual and predicted outcome
  logic  taken;
  logic  predicted;
  logic  is_branch;

  assign seq_pc  = pc + word_t'(`EXU_PC_STEP);
  assign rel_pc  = pc + val_c;
  assign ind_sum = val_a + val_c;

  assign is_branch = (jump == jmp_br_zero) || (jump == jmp_br_nonzero);

  always_comb begin
    taken       = 1'b0;
    redirect_pc = seq_pc;
    case (jump)
      jmp_jal: begin
        taken       = 1'b1;
        redirect_pc = rel_pc;
      end
      // jalr target has bit 0 forced low
      jmp_jalr: begin
        taken       = 1'b1;
        redirect_pc = {ind_sum[`EXU_WORD_BITS-1:1], 1'b0};
      end
      jmp_br_zero: begin
        taken       = (alu_result == '0);
        redirect_pc = taken ? rel_pc : seq_pc;
      end
      jmp_br_nonzero: begin
        taken       = (alu_result != '0);
        redirect_pc = taken ? rel_pc : seq_pc;
      end
      default: begin
        taken       = 1'b0;
        redirect_pc = seq_pc;
      end
    endcase
  end

  // backward taken, forward not taken
  // jumps are never predicted so they always redirect
  assign predicted  = is_branch & val_c[`EXU_WORD_BITS-1];
  assign mispredict = taken ^ predicted;

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exu_config.svh"

module execute_stage import exu_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  // decode side
  input  logic                     in_valid,
  output logic                     in_ready,
  input  word_t                    in_pc,
  input  word_t                    in_val_a,
  input  word_t                    in_val_b,
  input  word_t                    in_val_c,
  input  alu_op_e                  in_alu_op,
  input  logic                     in_alu_use_pc,
  input  jump_e                    in_jump,
  input  mem_e                     in_mem,
  input  wb_src_e                  in_wb_src,
  input  gpr_addr_t                in_rd,
  // write-back side
  output logic                     out_valid,
  input  logic                     out_ready,
  output gpr_addr_t                out_rd,
  output word_t                    out_data,
  // redirect and forwarding
  output logic                     jump_flush,
  output word_t                    jump_target,
  output gpr_addr_t                bypass_rd,
  output word_t                    bypass_data,
  // wishbone master
  output logic                     wb_cyc,
  output logic                     wb_stb,
  output logic                     wb_we,
  output word_t                    wb_adr,
  output word_t                    wb_dat_w,
  output logic [`EXU_SEL_BITS-1:0] wb_sel,
  input  word_t                    wb_dat_r,
  input  logic                     wb_ack
);

  word_t   pc;
  word_t   val_a;
  word_t   val_b;
  word_t   val_c;
  word_t   alu_a;
  alu_op_e alu_op;
  jump_e   jump;
  mem_e    mem;
  logic    mem_start;
  logic    mem_done;
  logic    mispredict;
  word_t   alu_result;
  word_t   load_data;
  word_t   redirect_pc;

  exu_control control0 (
    .clock, .reset,
    .in_valid, .in_ready, .in_pc, .in_val_a, .in_val_b, .in_val_c,
    .in_alu_op, .in_alu_use_pc, .in_jump, .in_mem, .in_wb_src, .in_rd,
    .out_valid, .out_ready, .out_rd, .out_data,
    .jump_flush, .jump_target, .bypass_rd, .bypass_data,
    .pc, .val_a, .val_b, .val_c, .alu_a, .alu_op, .jump, .mem, .mem_start,
    .alu_result, .load_data, .mem_done, .mispredict, .redirect_pc
  );

  alu alu0 (
    .a      (alu_a),
    .b      (val_b),
    .op     (alu_op),
    .result (alu_result)
  );

  branch_unit branch0 (
    .jump, .pc, .val_a, .val_c, .alu_result, .mispredict, .redirect_pc
  );

  // address from the alu, store data from val_c
  lsu lsu0 (
    .clock, .reset,
    .start      (mem_start),
    .op         (mem),
    .addr       (alu_result),
    .store_data (val_c),
    .done       (mem_done),
    .load_data,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack
  );

endmodule

`default_nettype wire

/* design/exu_control.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exu_config.svh"

module exu_control import exu_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  // decode side
  input  logic      in_valid,
  output logic      in_ready,
  input  word_t     in_pc,
  input  word_t     in_val_a,
  input  word_t     in_val_b,
  input  word_t     in_val_c,
  input  alu_op_e   in_alu_op,
  input  logic      in_alu_use_pc,
  input  jump_e     in_jump,
  input  mem_e      in_mem,
  input  wb_src_e   in_wb_src,
  input  gpr_addr_t in_rd,
  // write-back side
  output logic      out_valid,
  input  logic      out_ready,
  output gpr_addr_t out_rd,
  output word_t     out_data,
  // redirect and forwarding
  output logic      jump_flush,
  output word_t     jump_target,
  output gpr_addr_t bypass_rd,
  output word_t     bypass_data,
  // held operands
  output word_t     pc,
  output word_t     val_a,
  output word_t     val_b,
  output word_t     val_c,
  output word_t     alu_a,
  output alu_op_e   alu_op,
  output jump_e     jump,
  output mem_e      mem,
  output logic      mem_start,
  // datapath results
  input  word_t     alu_result,
  input  word_t     load_data,
  input  logic      mem_done,
  input  logic      mispredict,
  input  word_t     redirect_pc
);

  logic      valid;
  logic      use_pc;
  wb_src_e   wb_src;
  gpr_addr_t rd;
  // memory result already returned for the held instruction
  logic      mem_ok;
  logic      exec_done;
  logic      accept;
  logic      leaving;

  assign exec_done = (mem == mem_none) | mem_done | mem_ok;
  assign out_valid = valid & exec_done;
  assign leaving   = out_valid & out_ready;
  // refill in the same cycle the stage drains
  assign in_ready  = ~valid | leaving;
  assign accept    = in_valid & in_ready;
  assign mem_start = accept & (in_mem != mem_none);

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (accept) begin
      valid <= 1'b1;
    end else if (leaving) begin
      valid <= 1'b0;
    end
  end

  // done is a single pulse from the lsu
  always_ff @(posedge clock) begin
    if (reset) begin
      mem_ok <= 1'b0;
    end else if (leaving) begin
      mem_ok <= 1'b0;
    end else if (mem_done) begin
      mem_ok <= 1'b1;
    end
  end

  // stage register
  always_ff @(posedge clock) begin
    if (accept) begin
      pc     <= in_pc;
      val_a  <= in_val_a;
      val_b  <= in_val_b;
      val_c  <= in_val_c;
      alu_op <= in_alu_op;
      use_pc <= in_alu_use_pc;
      jump   <= in_jump;
      mem    <= in_mem;
      wb_src <= in_wb_src;
      rd     <= in_rd;
    end
  end

  // auipc and branch offsets use pc as operand a
  assign alu_a = use_pc ? pc : val_a;

  always_comb begin
    case (wb_src)
      src_operand: out_data = val_a;
      src_mem:     out_data = load_data;
      src_link:    out_data = pc + word_t'(`EXU_PC_STEP);
      default:     out_data = alu_result;
    endcase
  end

  assign out_rd = rd;

  // redirect only on the hand-off edge
  assign jump_flush  = leaving & mispredict;
  assign jump_target = leaving ? redirect_pc : '0;

  assign bypass_rd   = valid ? rd : '0;
  assign bypass_data = out_data;

  // stalled result is never overwritten by a new instruction
  assert property (@(posedge clock) disable iff (reset)
    (out_valid && !out_ready) |=> out_valid && $stable(out_rd) && $stable(out_data));

  // lsu needs at least the bus cycle and the done cycle
  assert property (@(posedge clock) disable iff (reset)
    mem_start |=> valid && !out_valid);

endmodule

`default_nettype wire

/* lsu/lsu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exu_config.svh"

module lsu import exu_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     start,
  input  mem_e                     op,
  input  word_t                    addr,
  input  word_t                    store_data,
  output logic                     done,
  output word_t                    load_data,
  output logic                     wb_cyc,
  output logic                     wb_stb,
  output logic                     wb_we,
  output word_t                    wb_adr,
  output word_t                    wb_dat_w,
  output logic [`EXU_SEL_BITS-1:0] wb_sel,
  input  word_t                    wb_dat_r,
  input  logic                     wb_ack
);

  typedef enum logic [1:0] {
    idle,
    bus,
    finish
  } lsu_state_e;

  lsu_state_e state;

  // byte offset inside the word
  logic [1:0] lane;
  logic       is_store;
  // read data moved down to bit 0
  word_t      shifted;
  word_t      ext_data;

  assign lane     = addr[1:0];
  assign is_store = (op == mem_sb) || (op == mem_sh) || (op == mem_sw);

  // one wishbone cycle per start
  // op, addr and store_data stay held by the stage register meanwhile
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle:    if (start) state <= bus;
        bus:     if (wb_ack) state <= finish;
        // back-to-back start when the stage drains this cycle
        finish:  state <= start ? bus : idle;
        default: state <= idle;
      endcase
    end
  end

  assign wb_cyc = (state == bus);
  assign wb_stb = wb_cyc;
  assign wb_we  = wb_cyc & is_store;
  assign wb_adr = {addr[`EXU_WORD_BITS-1:2], 2'b00};
  assign done   = (state == finish);

  // store data replicated on all lanes and select picks the bytes
  always_comb begin
    case (op)
      mem_lb, mem_lbu, mem_sb: begin
        wb_dat_w = {4{store_data[7:0]}};
        wb_sel   = 4'b0001 << lane;
      end
      mem_lh, mem_lhu, mem_sh: begin
        wb_dat_w = {2{store_data[15:0]}};
        wb_sel   = lane[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        wb_dat_w = store_data;
        wb_sel   = 4'b1111;
      end
    endcase
  end

  // load alignment and extension
  assign shifted = wb_dat_r >> {lane, 3'b000};

  always_comb begin
    case (op)
      mem_lb:  ext_data = {{(`EXU_WORD_BITS-8){shifted[7]}}, shifted[7:0]};
      mem_lbu: ext_data = {{(`EXU_WORD_BITS-8){1'b0}}, shifted[7:0]};
      mem_lh:  ext_data = {{(`EXU_WORD_BITS-16){shifted[15]}}, shifted[15:0]};
      mem_lhu: ext_data = {{(`EXU_WORD_BITS-16){1'b0}}, shifted[15:0]};
      default: ext_data = wb_dat_r;
    endcase
  end

  // captured on ack and held until the next cycle completes
  always_ff @(posedge clock) begin
    if (state == bus && wb_ack) begin
      load_data <= ext_data;
    end
  end

  // no new start while a bus cycle is still open
  assert property (@(posedge clock) disable iff (reset) start |-> (state != bus));

  // no abandoned bus cycle and the request stays put until ack
  assert property (@(posedge clock) disable iff (reset)
    (wb_cyc && !wb_ack) |=> wb_cyc && $stable(wb_adr) && $stable(wb_we) &&
      $stable(wb_sel) && $stable(wb_dat_w));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile and run the execute stage testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_execute_stage -f build.f

status=0
./obj_dir/Vtb_execute_stage > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation reported errors"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Everything OK" sim.log; then
  echo "simulation did not complete"
  exit 1
fi
exit 0

/* sim/tb_execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exu_config.svh"

module tb_execute_stage import exu_pkg::*; ();

  // one instruction with its expected results
  typedef struct {
    alu_op_e   op;
    logic      use_pc;
    jump_e     jump;
    mem_e      mem;
    wb_src_e   src;
    gpr_addr_t rd;
    word_t     pc;
    word_t     val_a;
    word_t     val_b;
    word_t     val_c;
    word_t     exp_data;
    logic      exp_flush;
    word_t     exp_target;
  } row_t;

  logic clock;
  logic reset;
  logic in_valid;
  logic in_ready;
  word_t in_pc;
  word_t in_val_a;
  word_t in_val_b;
  word_t in_val_c;
  alu_op_e in_alu_op;
  logic in_alu_use_pc;
  jump_e in_jump;
  mem_e in_mem;
  wb_src_e in_wb_src;
  gpr_addr_t in_rd;
  logic out_valid;
  logic out_ready;
  gpr_addr_t out_rd;
  word_t out_data;
  logic jump_flush;
  word_t jump_target;
  gpr_addr_t bypass_rd;
  word_t bypass_data;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  word_t wb_adr;
  word_t wb_dat_w;
  logic [`EXU_SEL_BITS-1:0] wb_sel;
  word_t wb_dat_r;
  logic wb_ack;

  row_t rows[$];
  // expected memory contents updated as store rows are added
  word_t shadow [256];
  word_t row_pc;
  int errors;
  int out_count;
  // values seen in a stalled cycle
  logic held;
  word_t held_data;
  gpr_addr_t held_rd;

  execute_stage dut0 (.*);

  wb_mem_model mem0 (
    .clock, .reset,
    .cyc (wb_cyc), .stb (wb_stb), .we (wb_we), .adr (wb_adr),
    .dat_w (wb_dat_w), .sel (wb_sel), .dat_r (wb_dat_r), .ack (wb_ack)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic check_word(string name, word_t actual, word_t expected);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic check_rd(string name, gpr_addr_t actual, gpr_addr_t expected);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t %s: got %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  task automatic check_flush(string name, logic actual, logic expected);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t %s: got %b, expected %b", $time, name, actual, expected);
    end
  endtask

  // rv32i integer rules
  function automatic word_t expect_alu(alu_op_e op, word_t a, word_t b);
    logic [4:0] sh;
    word_t      fill;
    sh = b[4:0];
    // ones entering from the top for sra of a negative value
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a + ~b + 32'd1;
      alu_sll:  return a << sh;
      alu_slt:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
      alu_sltu: return {31'd0, a < b};
      alu_xor:  return a ^ b;
      alu_srl:  return a >> sh;
      alu_sra:  return (a >> sh) | fill;
      alu_or:   return a | b;
      alu_and:  return a & b;
      default:  return 32'h0;
    endcase
  endfunction

  function automatic word_t expect_load(mem_e op, word_t addr);
    word_t       w;
    logic [7:0]  b;
    logic [15:0] h;
    w = shadow[addr[9:2]];
    b = w[{addr[1:0], 3'b000} +: 8];
    h = w[{addr[1], 4'b0000} +: 16];
    case (op)
      mem_lb:  return {{24{b[7]}}, b};
      mem_lbu: return {24'd0, b};
      mem_lh:  return {{16{h[15]}}, h};
      mem_lhu: return {16'd0, h};
      default: return w;
    endcase
  endfunction

  function automatic void apply_store(mem_e op, word_t addr, word_t data);
    case (op)
      mem_sb:  shadow[addr[9:2]][{addr[1:0], 3'b000} +: 8] = data[7:0];
      mem_sh:  shadow[addr[9:2]][{addr[1], 4'b0000} +: 16] = data[15:0];
      mem_sw:  shadow[addr[9:2]] = data;
      default: ;
    endcase
  endfunction

  // builds one row with expected values from the stage rules
  function automatic void add_row(alu_op_e op, logic use_pc, jump_e jump, mem_e mem,
                                  wb_src_e src, gpr_addr_t rd, word_t a, word_t b, word_t c);
    row_t  r;
    word_t res;
    logic  taken;
    logic  predicted;
    r.op = op;
    r.use_pc = use_pc;
    r.jump = jump;
    r.mem = mem;
    r.src = src;
    r.rd = rd;
    r.pc = row_pc;
    r.val_a = a;
    r.val_b = b;
    r.val_c = c;
    res = expect_alu(op, use_pc ? row_pc : a, b);
    case (src)
      src_operand: r.exp_data = a;
      src_link:    r.exp_data = row_pc + 32'd4;
      src_mem:     r.exp_data = expect_load(mem, res);
      default:     r.exp_data = res;
    endcase
    // store data travels in val_c
    if (mem == mem_sb || mem == mem_sh || mem == mem_sw) begin
      apply_store(mem, res, c);
    end
    taken = (jump == jmp_jal) || (jump == jmp_jalr) ||
            (jump == jmp_br_zero && res == 32'h0) ||
            (jump == jmp_br_nonzero && res != 32'h0);
    // static prediction takes backward branches
    predicted = (jump == jmp_br_zero || jump == jmp_br_nonzero) && c[31];
    r.exp_flush = taken != predicted;
    if (jump == jmp_jalr) begin
      r.exp_target = (a + c) & 32'hffff_fffe;
    end else begin
      r.exp_target = taken ? row_pc + c : row_pc + 32'd4;
    end
    rows.push_back(r);
    row_pc = row_pc + 32'd4;
  endfunction

  function automatic void build_table();
    word_t pairs_a [3];
    word_t pairs_b [3];
    pairs_a = '{32'hf000_0005, 32'h0000_0005, 32'h8000_0000};
    pairs_b = '{32'h0000_0003, 32'hffff_fffd, 32'h0000_001f};
    for (int i = 0; i < 256; i++) begin
      shadow[i] = word_t'(i) * 32'h0101_0101 + 32'h10;
    end
    row_pc = 32'h0000_1000;
    // every alu op with and without pc as operand a
    for (int k = 0; k < 10; k++) begin
      for (int u = 0; u < 2; u++) begin
        for (int p = 0; p < 3; p++) begin
          add_row(alu_op_e'(k[3:0]), u[0], jmp_none, mem_none, src_alu,
                  gpr_addr_t'(k + 1), pairs_a[p], pairs_b[p], 32'h0);
        end
      end
    end
    // write-back sources for lui, link and no write
    add_row(alu_add, 1'b0, jmp_none, mem_none, src_operand, 5'd7, 32'h1234_5000, 32'h0, 32'h0);
    add_row(alu_add, 1'b0, jmp_none, mem_none, src_link, 5'd3, 32'h0, 32'h0, 32'h0);
    add_row(alu_add, 1'b0, jmp_none, mem_none, src_alu, 5'd0, 32'h11, 32'h22, 32'h0);
    // jumps
    add_row(alu_add, 1'b0, jmp_jal, mem_none, src_link, 5'd1, 32'h0, 32'h0, 32'h40);
    add_row(alu_add, 1'b0, jmp_jal, mem_none, src_link, 5'd1, 32'h0, 32'h0, 32'hffff_fff8);
    add_row(alu_add, 1'b0, jmp_jalr, mem_none, src_link, 5'd1, 32'h2001, 32'h0, 32'h10);
    // backward and forward branches both taken and not taken
    add_row(alu_sub, 1'b0, jmp_br_zero, mem_none, src_alu, 5'd0, 32'd5, 32'd5, 32'hffff_fff0);
    add_row(alu_sub, 1'b0, jmp_br_zero, mem_none, src_alu, 5'd0, 32'd5, 32'd6, 32'hffff_fff0);
    add_row(alu_sub, 1'b0, jmp_br_zero, mem_none, src_alu, 5'd0, 32'd7, 32'd7, 32'h20);
    add_row(alu_sub, 1'b0, jmp_br_zero, mem_none, src_alu, 5'd0, 32'd7, 32'd8, 32'h20);
    add_row(alu_sub, 1'b0, jmp_br_nonzero, mem_none, src_alu, 5'd0, 32'd3, 32'd4, 32'hffff_fff8);
    add_row(alu_sub, 1'b0, jmp_br_nonzero, mem_none, src_alu, 5'd0, 32'd3, 32'd3, 32'h10);
    // loads at each legal offset of a word with negative bytes and one without
    for (int w = 0; w < 2; w++) begin
      for (int off = 0; off < 4; off++) begin
        add_row(alu_add, 1'b0, jmp_none, mem_lb, src_mem, 5'd9,
                w == 0 ? 32'h200 : 32'hd4, word_t'(off), 32'h0);
        add_row(alu_add, 1'b0, jmp_none, mem_lbu, src_mem, 5'd10,
                w == 0 ? 32'h200 : 32'hd4, word_t'(off), 32'h0);
      end
      for (int off = 0; off < 4; off += 2) begin
        add_row(alu_add, 1'b0, jmp_none, mem_lh, src_mem, 5'd11,
                w == 0 ? 32'h200 : 32'hd4, word_t'(off), 32'h0);
        add_row(alu_add, 1'b0, jmp_none, mem_lhu, src_mem, 5'd12,
                w == 0 ? 32'h200 : 32'hd4, word_t'(off), 32'h0);
      end
      add_row(alu_add, 1'b0, jmp_none, mem_lw, src_mem, 5'd13,
              w == 0 ? 32'h200 : 32'hd4, 32'h0, 32'h0);
    end
    // stores merged into the word and read back after each
    add_row(alu_add, 1'b0, jmp_none, mem_sw, src_alu, 5'd0, 32'h100, 32'h0, 32'hdead_beef);
    add_row(alu_add, 1'b0, jmp_none, mem_lw, src_mem, 5'd14, 32'h100, 32'h0, 32'h0);
    add_row(alu_add, 1'b0, jmp_none, mem_sb, src_alu, 5'd0, 32'h100, 32'h1, 32'h0000_005a);
    add_row(alu_add, 1'b0, jmp_none, mem_lw, src_mem, 5'd14, 32'h100, 32'h0, 32'h0);
    add_row(alu_add, 1'b0, jmp_none, mem_sh, src_alu, 5'd0, 32'h100, 32'h2, 32'h0000_1234);
    add_row(alu_add, 1'b0, jmp_none, mem_lw, src_mem, 5'd14, 32'h100, 32'h0, 32'h0);
    add_row(alu_add, 1'b0, jmp_none, mem_sb, src_alu, 5'd0, 32'h100, 32'h3, 32'h0000_0080);
    add_row(alu_add, 1'b0, jmp_none, mem_lb, src_mem, 5'd15, 32'h100, 32'h3, 32'h0);
    add_row(alu_add, 1'b0, jmp_none, mem_sh, src_alu, 5'd0, 32'h104, 32'h0, 32'h0000_9abc);
    add_row(alu_add, 1'b0, jmp_none, mem_lhu, src_mem, 5'd16, 32'h104, 32'h0, 32'h0);
    add_row(alu_add, 1'b0, jmp_none, mem_lw, src_mem, 5'd17, 32'h104, 32'h0, 32'h0);
  endfunction

  task automatic drive_row(row_t r);
    in_valid      <= 1'b1;
    in_pc         <= r.pc;
    in_val_a      <= r.val_a;
    in_val_b      <= r.val_b;
    in_val_c      <= r.val_c;
    in_alu_op     <= r.op;
    in_alu_use_pc <= r.use_pc;
    in_jump       <= r.jump;
    in_mem        <= r.mem;
    in_wb_src     <= r.src;
    in_rd         <= r.rd;
  endtask

  // random back-pressure drops ready about one cycle in four
  initial begin
    out_ready <= 1'b0;
    forever begin
      @(posedge clock);
      out_ready <= ($urandom % 4) != 0;
    end
  end

  // output monitor sampled mid-cycle
  initial begin
    held = 1'b0;
    forever begin
      @(negedge clock);
      if (!reset) begin
        if (held) begin
          check_flush("out_valid", out_valid, 1'b1);
          check_word("out_data", out_data, held_data);
          check_rd("out_rd", out_rd, held_rd);
        end
        held = 1'b0;
        if (out_valid && out_ready) begin
          if (out_count >= rows.size()) begin
            errors++;
            $display("extra output hand-off at %0t beyond the table", $time);
          end else begin
            check_word("out_data", out_data, rows[out_count].exp_data);
            check_rd("out_rd", out_rd, rows[out_count].rd);
            check_flush("jump_flush", jump_flush, rows[out_count].exp_flush);
            check_word("jump_target", jump_target, rows[out_count].exp_target);
            check_rd("bypass_rd", bypass_rd, rows[out_count].rd);
            check_word("bypass_data", bypass_data, rows[out_count].exp_data);
          end
          out_count++;
        end else if (out_valid) begin
          // stalled by write-back
          check_flush("in_ready", in_ready, 1'b0);
          check_flush("jump_flush", jump_flush, 1'b0);
          held      = 1'b1;
          held_data = out_data;
          held_rd   = out_rd;
        end
      end
    end
  end

  // limit from the table length
  initial begin
    @(posedge clock);
    repeat (rows.size() * 20 + 20) @(posedge clock);
    $display("timeout: %0d of %0d outputs seen", out_count, rows.size());
    $display("Something failed");
    $finish;
  end

  initial begin
    logic accepted;
    void'($urandom(32'h57bfa579));
    errors = 0;
    out_count = 0;
    reset <= 1'b1;
    in_valid <= 1'b0;
    in_pc <= '0;
    in_val_a <= '0;
    in_val_b <= '0;
    in_val_c <= '0;
    in_alu_op <= alu_add;
    in_alu_use_pc <= 1'b0;
    in_jump <= jmp_none;
    in_mem <= mem_none;
    in_wb_src <= src_alu;
    in_rd <= '0;
    build_table();
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_flush("out_valid", out_valid, 1'b0);
    check_flush("in_ready", in_ready, 1'b1);
    check_flush("jump_flush", jump_flush, 1'b0);
    check_flush("wb_cyc", wb_cyc, 1'b0);
    check_flush("wb_stb", wb_stb, 1'b0);
    check_rd("bypass_rd", bypass_rd, 5'd0);
    @(posedge clock);
    for (int i = 0; i < rows.size(); i++) begin
      drive_row(rows[i]);
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clock);
        accepted = in_ready;
        @(posedge clock);
      end
    end
    in_valid <= 1'b0;
    while (out_count < rows.size()) @(posedge clock);
    // a few idle cycles to catch duplicates
    repeat (5) @(posedge clock);
    check_flush("wb_cyc", wb_cyc, 1'b0);
    $display("errors: %0d, hand-offs: %0d of %0d", errors, out_count, rows.size());
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/wb_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

`include "exu_config.svh"

module wb_mem_model import exu_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     cyc,
  input  logic                     stb,
  input  logic                     we,
  input  word_t                    adr,
  input  word_t                    dat_w,
  input  logic [`EXU_SEL_BITS-1:0] sel,
  output word_t                    dat_r,
  output logic                     ack
);

  // 256 words, byte address bits 9:2
  word_t       mem [256];
  logic        busy;
  int unsigned wait_left;
  logic [7:0]  index;

  assign index = adr[9:2];

  always_ff @(posedge clock) begin
    if (reset) begin
      // fill depends on the whole word index
      for (int i = 0; i < 256; i++) begin
        mem[i] <= word_t'(i) * 32'h0101_0101 + 32'h10;
      end
      busy      <= 1'b0;
      ack       <= 1'b0;
      wait_left <= 0;
      dat_r     <= '0;
    end else if (ack) begin
      // single-cycle ack, master drops cyc on this edge
      ack  <= 1'b0;
      busy <= 1'b0;
    end else if (cyc && stb) begin
      if (!busy) begin
        busy      <= 1'b1;
        wait_left <= $urandom % 4;
      end else if (wait_left == 0) begin
        ack   <= 1'b1;
        dat_r <= mem[index];
        // only the selected byte lanes are written
        if (we) begin
          for (int b = 0; b < `EXU_SEL_BITS; b++) begin
            if (sel[b]) begin
              mem[index][8*b +: 8] <= dat_w[8*b +: 8];
            end
          end
        end
      end else begin
        wait_left <= wait_left - 1;
      end
    end
  end

endmodule

`default_nettype wire
